//--- Makefile
# Verilator build and run of the cpucr testbench

.PHONY: sim clean

sim:
	verilator --binary -j 0 --top-module cpucrTb -f cpucr.f -Mdir obj_dir
	./obj_dir/VcpucrTb | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- cpucr.f
+incdir+logic
logic/cpuPkg.sv
logic/cpuCtrlIf.sv
logic/sequencer.sv
logic/accumulator.sv
logic/addressUnit.sv
logic/cpucr.sv
testbench/cpucrTb.sv

//--- logic/accumulator.sv
//******************************
// Accumulator, ALU and flags
// Z and N track the accumulator
//******************************
`default_nettype none
`include "cpuCfg.svh"

module accumulator (
	input logic CLK,
	input logic rstN,
	input logic [`CPU_DATA_W-1:0] dataIn,
	cpuCtrlIf.acc ctrl,
	output logic [`CPU_DATA_W-1:0] dataOut
);
	localparam int Msb = `CPU_DATA_W - 1;

	cpuPkg::aluOpT op;
	logic useData;
	logic useImplied;
	logic [Msb:0] addB;
	logic addCin;
	logic [`CPU_DATA_W:0] sum;
	logic sumOvf;

	assign op = cpuPkg::aluOpT'(ctrl.instr.fields.op);

	assign useData =
		(ctrl.state == cpuPkg::stOperandLowData && ctrl.instr.fields.mode == cpuPkg::mImmediate) ||
		(ctrl.state == cpuPkg::stAccessData && ctrl.instr.fields.mode == cpuPkg::mDirect);
	assign useImplied = ctrl.state == cpuPkg::stExecute &&
		ctrl.instr.fields.mode == cpuPkg::mImplied;

	// One adder for ADD, SUB, INA and DCA
	always_comb begin
		addB = dataIn;
		addCin = 1'b0;
		case (op)
			cpuPkg::opSub: begin
				addB = ~dataIn;  // C set means no borrow
				addCin = 1'b1;
			end
			cpuPkg::opIna: begin
				addB = '0;
				addCin = 1'b1;
			end
			cpuPkg::opDca: addB = '1;
			default: ;
		endcase
	end

	assign sum = {1'b0, ctrl.accum} + {1'b0, addB} + {{`CPU_DATA_W{1'b0}}, addCin};
	assign sumOvf = (ctrl.accum[Msb] == addB[Msb]) && (sum[Msb] != ctrl.accum[Msb]);

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			ctrl.accum <= '0;
			ctrl.carry <= 1'b0;
			ctrl.overflow <= 1'b0;
		end else if (useData) begin
			case (op)
				cpuPkg::opLd: ctrl.accum <= dataIn;
				cpuPkg::opAdd, cpuPkg::opSub: begin
					ctrl.accum <= sum[Msb:0];
					ctrl.carry <= sum[`CPU_DATA_W];
					ctrl.overflow <= sumOvf;
				end
				cpuPkg::opAnd: ctrl.accum <= ctrl.accum & dataIn;
				cpuPkg::opOr: ctrl.accum <= ctrl.accum | dataIn;
				default: ;
			endcase
		end else if (useImplied) begin
			case (op)
				cpuPkg::opCla: ctrl.accum <= '0;
				cpuPkg::opIna, cpuPkg::opDca: begin
					ctrl.accum <= sum[Msb:0];
					ctrl.carry <= sum[`CPU_DATA_W];
					ctrl.overflow <= sumOvf;
				end
				cpuPkg::opRol: begin
					ctrl.accum <= {ctrl.accum[Msb-1:0], ctrl.carry};  // Through carry
					ctrl.carry <= ctrl.accum[Msb];
				end
				cpuPkg::opRor: begin
					ctrl.accum <= {ctrl.carry, ctrl.accum[Msb:1]};
					ctrl.carry <= ctrl.accum[0];
				end
				cpuPkg::opCpa: ctrl.accum <= ~ctrl.accum;
				cpuPkg::opClc: ctrl.carry <= 1'b0;
				cpuPkg::opSec: ctrl.carry <= 1'b1;
				default: ;  // NOP
			endcase
		end
	end

	assign ctrl.zero = ~|ctrl.accum;
	assign ctrl.negative = ctrl.accum[Msb];
	assign dataOut = ctrl.accum;
endmodule

`default_nettype wire

//--- logic/addressUnit.sv
//******************************
// Program counter, operand
// address and branch decision
// Selects the bus address
//******************************
`default_nettype none
`include "cpuCfg.svh"

module addressUnit (
	input logic CLK,
	input logic rstN,
	input logic [`CPU_DATA_W-1:0] dataIn,
	cpuCtrlIf.addr ctrl,
	output logic [`CPU_ADDR_W-1:0] addr
);
	localparam int ExtW = `CPU_ADDR_W - `CPU_DATA_W;

	logic [`CPU_ADDR_W-1:0] pc;
	logic [`CPU_ADDR_W-1:0] opAddr;  // Gathered direct address
	logic [`CPU_ADDR_W-1:0] offset;
	cpuPkg::branchCondT cond;
	logic taken;

	assign cond = cpuPkg::branchCondT'(ctrl.instr.fields.op);

	always_comb begin
		case (cond)
			cpuPkg::brCc: taken = !ctrl.carry;
			cpuPkg::brCs: taken = ctrl.carry;
			cpuPkg::brNe: taken = !ctrl.zero;
			cpuPkg::brEq: taken = ctrl.zero;
			cpuPkg::brPl: taken = !ctrl.negative;
			cpuPkg::brMi: taken = ctrl.negative;
			cpuPkg::brVc: taken = !ctrl.overflow;
			cpuPkg::brVs: taken = ctrl.overflow;
			default: taken = 1'b0;
		endcase
	end

	// Signed offset byte
	assign offset = {{ExtW{dataIn[`CPU_DATA_W-1]}}, dataIn};

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			pc <= `CPU_RESET_VECTOR;
		end else begin
			case (ctrl.state)
				cpuPkg::stFetch, cpuPkg::stOperandLow, cpuPkg::stOperandHigh:
					pc <= pc + `CPU_ADDR_W'(1);  // Step past each fetched byte
				cpuPkg::stOperandLowData: begin
					// PC already points past the offset byte
					if (ctrl.instr.fields.mode == cpuPkg::mBranch && taken)
						pc <= pc + offset;
				end
				cpuPkg::stOperandHighData: begin
					if (ctrl.instr.fields.mode == cpuPkg::mJump)
						pc <= {dataIn, opAddr[`CPU_DATA_W-1:0]};
				end
				default: ;
			endcase
		end
	end

	// Low byte first, then high byte
	always_ff @(posedge CLK) begin
		if (ctrl.state == cpuPkg::stOperandLowData)
			opAddr[`CPU_DATA_W-1:0] <= dataIn;
		if (ctrl.state == cpuPkg::stOperandHighData)
			opAddr[`CPU_ADDR_W-1:`CPU_DATA_W] <= dataIn;
	end

	assign addr = (ctrl.state == cpuPkg::stAccess) ? opAddr : pc;
endmodule

`default_nettype wire

//--- logic/cpuCfg.svh
//******************************
// Build constants of the CPU
// Include in each RTL file that
// needs widths or reset values
//******************************
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_DATA_W 8
`define CPU_ADDR_W 16
`define CPU_RESET_VECTOR 16'h0000  // First fetch address

// Halt bit is XORed with this every cycle while trapped
`define CPU_TRAP_TOGGLE 1'b1

`endif

//--- logic/cpuCtrlIf.sv
//******************************
// Control bundle shared by the
// sequencer, accumulator and
// address unit of the CPU
//******************************
`default_nettype none
`include "cpuCfg.svh"

interface cpuCtrlIf;
	cpuPkg::cpuStateT state;
	cpuPkg::instrWordT instr;  // Valid from stExecute on
	logic [`CPU_DATA_W-1:0] accum;
	logic carry;
	logic zero;
	logic negative;
	logic overflow;

	modport seq (output state, output instr,
		input carry, input zero, input negative, input overflow);

	modport acc (input state, input instr,
		output accum, output carry, output zero, output negative, output overflow);

	modport addr (input state, input instr,
		input carry, input zero, input negative, input overflow);

	// Observation only
	modport top (input state, input instr, input accum,
		input carry, input zero, input negative, input overflow);
endinterface

`default_nettype wire

//--- logic/cpuPkg.sv
//******************************
// Types shared by the CPU units
// Referenced as cpuPkg::name
//******************************
`default_nettype none
`include "cpuCfg.svh"

package cpuPkg;

	// Sequencer states, one cycle each
	typedef enum logic [3:0] {
		stFetch,
		stDecode,
		stExecute,
		stOperandLow,
		stOperandLowData,
		stOperandHigh,
		stOperandHighData,
		stAccess,
		stAccessData,
		stHalt,
		stTrap
	} cpuStateT;

	// Upper three opcode bits, value 7 is unused
	typedef enum logic [2:0] {
		mImplied,
		mImmediate,
		mDirect,
		mStore,
		mBranch,
		mJump,
		mHalt
	} addrModeT;

	typedef enum logic [4:0] {
		opLd, opAdd, opSub, opAnd, opOr,  // Operand group
		opCla, opIna, opDca, opRol, opRor, opCpa, opClc, opSec, opNop  // Implied group
	} aluOpT;

	typedef enum logic [4:0] {
		brCc, brCs, brNe, brEq, brPl, brMi, brVc, brVs
	} branchCondT;

	typedef struct packed {
		addrModeT mode;
		logic [`CPU_DATA_W-4:0] op;  // aluOpT or branchCondT by mode
	} instrFieldsT;

	// Opcode byte seen whole or split
	typedef union packed {
		logic [`CPU_DATA_W-1:0] raw;
		instrFieldsT fields;
	} instrWordT;

endpackage

`default_nettype wire

//--- logic/cpucr.sv
//******************************
// CPU top level with a plain
// memory bus, one byte per cycle
// rdWr low means write
//******************************
`default_nettype none
`include "cpuCfg.svh"

module cpucr (
	input logic CLK,
	input logic rstN,
	output logic [`CPU_ADDR_W-1:0] addr,
	input logic [`CPU_DATA_W-1:0] dataIn,
	output logic [`CPU_DATA_W-1:0] dataOut,
	output logic rdWr,
	output logic halt
);
	cpuCtrlIf ctrlBus ();

	sequencer sequencer_i (
		.CLK(CLK),
		.rstN(rstN),
		.dataIn(dataIn),
		.ctrl(ctrlBus.seq),
		.rdWr(rdWr),
		.halt(halt)
	);

	accumulator accumulator_i (
		.CLK(CLK),
		.rstN(rstN),
		.dataIn(dataIn),
		.ctrl(ctrlBus.acc),
		.dataOut(dataOut)  // Store data is always the accumulator
	);

	addressUnit addressUnit_i (
		.CLK(CLK),
		.rstN(rstN),
		.dataIn(dataIn),
		.ctrl(ctrlBus.addr),
		.addr(addr)
	);
endmodule

`default_nettype wire

//--- logic/sequencer.sv
//******************************
// Instruction register and state
// sequencer, also drives rdWr
// and the halt output
//******************************
`default_nettype none
`include "cpuCfg.svh"

module sequencer (
	input logic CLK,
	input logic rstN,
	input logic [`CPU_DATA_W-1:0] dataIn,
	cpuCtrlIf.seq ctrl,
	output logic rdWr,
	output logic halt
);
	cpuPkg::instrWordT fetched;
	cpuPkg::cpuStateT nextState;
	logic legal;

	// Mode must be listed and op must fit that mode
	function automatic logic opLegal(cpuPkg::instrWordT w);
		logic ok;
		case (w.fields.mode)
			cpuPkg::mImplied:
				ok = (w.fields.op >= 5'(cpuPkg::opCla)) && (w.fields.op <= 5'(cpuPkg::opNop));
			cpuPkg::mImmediate, cpuPkg::mDirect:
				ok = w.fields.op <= 5'(cpuPkg::opOr);
			cpuPkg::mBranch:
				ok = w.fields.op <= 5'(cpuPkg::brVs);
			cpuPkg::mStore, cpuPkg::mJump, cpuPkg::mHalt:
				ok = w.fields.op == '0;
			default:
				ok = 1'b0;
		endcase
		return ok;
	endfunction

	assign fetched.raw = dataIn;  // Opcode is on the bus during stDecode
	assign legal = opLegal(fetched);

	always_ff @(posedge CLK) begin
		if (ctrl.state == cpuPkg::stDecode)
			ctrl.instr <= fetched;
	end

	always_comb begin
		nextState = cpuPkg::stTrap;
		case (ctrl.state)
			cpuPkg::stFetch: nextState = cpuPkg::stDecode;
			cpuPkg::stDecode: nextState = legal ? cpuPkg::stExecute : cpuPkg::stTrap;
			cpuPkg::stExecute: begin
				if (ctrl.instr.fields.mode == cpuPkg::mImplied)
					nextState = cpuPkg::stFetch;
				else if (ctrl.instr.fields.mode == cpuPkg::mHalt)
					nextState = cpuPkg::stHalt;
				else
					nextState = cpuPkg::stOperandLow;
			end
			cpuPkg::stOperandLow: nextState = cpuPkg::stOperandLowData;
			cpuPkg::stOperandLowData: begin
				// Single operand byte for immediate and branch
				if (ctrl.instr.fields.mode == cpuPkg::mImmediate ||
						ctrl.instr.fields.mode == cpuPkg::mBranch)
					nextState = cpuPkg::stFetch;
				else
					nextState = cpuPkg::stOperandHigh;
			end
			cpuPkg::stOperandHigh: nextState = cpuPkg::stOperandHighData;
			cpuPkg::stOperandHighData: begin
				if (ctrl.instr.fields.mode == cpuPkg::mJump)
					nextState = cpuPkg::stFetch;
				else
					nextState = cpuPkg::stAccess;
			end
			cpuPkg::stAccess: begin
				if (ctrl.instr.fields.mode == cpuPkg::mStore)
					nextState = cpuPkg::stFetch;  // Write happens at end of stAccess
				else
					nextState = cpuPkg::stAccessData;
			end
			cpuPkg::stAccessData: nextState = cpuPkg::stFetch;
			cpuPkg::stHalt: nextState = cpuPkg::stHalt;
			default: nextState = cpuPkg::stTrap;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			ctrl.state <= cpuPkg::stFetch;
			halt <= 1'b0;
		end else begin
			ctrl.state <= nextState;
			if (nextState == cpuPkg::stHalt)
				halt <= 1'b1;
			else if (nextState == cpuPkg::stTrap)
				halt <= (ctrl.state == cpuPkg::stTrap) ? halt ^ `CPU_TRAP_TOGGLE : 1'b1;
			else
				halt <= 1'b0;
		end
	end

	assign rdWr = !(ctrl.state == cpuPkg::stAccess && ctrl.instr.fields.mode == cpuPkg::mStore);
endmodule

`default_nettype wire

//--- testbench/cpucrGolden.hex
// Each line holds hex bytes placed upward from the last @ address
// Records at 8000 are a count byte and then addrLow addrHigh data per write
@0000
20 5A 21 37 60 00 41          // LDA #5A; ADD #37; STA 4100
22 12 23 F0 24 05 60 01 41    // SUB #12; AND #F0; ORA #05; STA 4101
06 06 07 60 02 41             // INA; INA; DCA; STA 4102
08 60 03 41                   // ROL; STA 4103
0C 09 0B 09 60 04 41          // SEC; ROR; CLC; ROR; STA 4104
0A 0D 60 05 41                // CPA; NOP; STA 4105
05 60 06 41                   // CLA; STA 4106
40 00 40 41 01 40 42 02 40    // Direct LDA ADD SUB
44 03 40 43 04 40 60 34 12    // Direct ORA AND; STA 1234
80 03 60 00 42 81 03 60 FF 4F // BCC not taken; BCS taken
82 03 60 FF 4F 83 03 60 01 42 // BNE taken; BEQ not taken
84 03 60 02 42 85 03 60 FF 4F // BPL not taken; BMI taken
86 03 60 FF 4F 87 03 60 03 42 // BVC taken; BVS not taken
20 80 21 80 0B                // Flags become C=0 Z=1 N=0 V=1
80 03 60 FF 4F 81 03 60 04 42
82 03 60 05 42 83 03 60 FF 4F
84 03 60 FF 4F 85 03 60 06 42
86 03 60 07 42 87 03 60 FF 4F
20 02 60 08 42 07 82 FA       // Count down loop with backward BNE
A0 A0 00 60 FF 4F             // JMP 00A0 over a poison store
@00A0
C0                            // HLT
@4000
C3 55 0F 80 F8
@8000
12
00 41 91 01 41 75 02 41 76 03 41 ED 04 41 7B 05 41 84
06 41 00 34 12 88 00 42 88 01 42 88 02 42 88 03 42 88
04 42 00 05 42 00 06 42 00 07 42 00 08 42 02 08 42 01

//--- testbench/cpucrTb.sv
//******************************
// Testbench for the cpucr CPU
// Runs the golden program image
// and checks every memory write
//******************************
`default_nettype none
`include "cpuCfg.svh"

module cpucrTb;
	localparam logic [15:0] RecBase = 16'h8000;  // Count byte, then 3-byte records
	localparam int HaltTimeout = 2000;

	logic CLK;
	logic rstN;
	logic [`CPU_ADDR_W-1:0] addr;
	logic [`CPU_DATA_W-1:0] dataIn;
	logic [`CPU_DATA_W-1:0] dataOut;
	logic rdWr;
	logic halt;

	logic [7:0] mem [0:65535];
	logic [`CPU_ADDR_W-1:0] busAddr;
	logic [`CPU_DATA_W-1:0] busData;
	logic busRdWr;
	int recCount;
	int writeIdx = 0;
	logic lastHalt;

	cpucr cpucr_i (
		.CLK(CLK),
		.rstN(rstN),
		.addr(addr),
		.dataIn(dataIn),
		.dataOut(dataOut),
		.rdWr(rdWr),
		.halt(halt)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected)
			failRun($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h",
				name, actual, expected));
	endtask

	// Ten rising edges with rstN low, then one half cycle
	task automatic applyReset();
		@(posedge CLK);
		rstN <= 1'b0;
		repeat (10) @(posedge CLK);
		rstN <= 1'b1;
		@(negedge CLK);
	endtask

	task automatic waitForHalt(input int limit);
		int n;
		n = 0;
		while (halt !== 1'b1) begin
			if (n >= limit)
				failRun("timed out waiting for the halt output to rise");
			else begin
				@(negedge CLK);
				n++;
			end
		end
	endtask

	// Bus is stable mid cycle
	always @(negedge CLK) begin
		busAddr <= addr;
		busRdWr <= rdWr;
		busData <= dataOut;
	end

	// Memory answers by the next edge and writes when rdWr was low
	always @(posedge CLK) begin
		logic [15:0] rec;
		dataIn <= mem[busAddr];
		if (busRdWr === 1'b0) begin
			mem[busAddr] = busData;
			if (writeIdx >= recCount)
				failRun($sformatf("unexpected write to 0x%h after all %0d records",
					busAddr, recCount));
			else begin
				rec = 16'(RecBase + 1 + 3 * writeIdx);
				checkValue("addr", 32'(busAddr), {16'h0, mem[rec + 16'd1], mem[rec]});
				checkValue("dataOut", 32'(busData), 32'(mem[rec + 16'd2]));
				writeIdx++;
			end
		end
	end

	initial begin
		rstN <= 1'b0;
		dataIn <= '0;
		busRdWr <= 1'b1;
		$readmemh("testbench/cpucrGolden.hex", mem);
		recCount = int'(mem[RecBase]);

		applyReset();
		checkValue("addr", 32'(addr), 32'(`CPU_RESET_VECTOR));
		checkValue("rdWr", 32'(rdWr), 32'd1);
		checkValue("halt", 32'(halt), 32'd0);

		// Program ends in HLT
		waitForHalt(HaltTimeout);
		repeat (20) begin
			@(negedge CLK);
			checkValue("halt", 32'(halt), 32'd1);
			checkValue("rdWr", 32'(rdWr), 32'd1);
		end
		checkValue("write count", 32'(writeIdx), 32'(recCount));

		// Illegal opcode at the reset vector
		mem[`CPU_RESET_VECTOR] = 8'hFF;
		applyReset();
		waitForHalt(HaltTimeout);
		lastHalt = 1'b1;
		repeat (16) begin
			@(negedge CLK);
			checkValue("halt", 32'(halt), 32'(!lastHalt));  // Toggles each cycle
			checkValue("rdWr", 32'(rdWr), 32'd1);
			lastHalt = !lastHalt;
		end

		$display("all tests passed");
		$finish;
	end
endmodule

`default_nettype wire
